//--- bench/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

endmodule

//--- bench/tb_mips_cpu.sv
`include "mips_params.svh"

module tb_mips_cpu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PROG_LEN   = 60;
  localparam int NUM_PROGS  = 4;
  localparam int DMEM_WORDS = 64;
  localparam int TIMEOUT_NS = NUM_PROGS * (PROG_LEN + 10) * 20 * 2;
  localparam logic [31:0] DMEM_BASE = 32'h1000_0000;

  logic        clk;
  logic        reset;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;

  logic [31:0] prog [64];
  logic [31:0] dmem [64];
  logic [31:0] ref_regs [32];
  logic [31:0] ref_dmem [64];
  logic [31:0] pc_trace [$];
  logic [31:0] st_addr [$];
  logic [31:0] st_data [$];
  logic [31:0] ld_addr [$];
  logic [31:0] rng_state;
  logic [31:0] ioff;

  tb_clock_gen u_clk (
    .clk (clk)
  );

  mips_cpu_harvard UUT (
    .clk            (clk),
    .reset          (reset),
    .active         (active),
    .register_v0    (register_v0),
    .clk_enable     (clk_enable),
    .instr_address  (instr_address),
    .instr_readdata (instr_readdata),
    .data_address   (data_address),
    .data_write     (data_write),
    .data_read      (data_read),
    .data_writedata (data_writedata),
    .data_readdata  (data_readdata)
  );

  // instruction memory, program placed at the reset vector
  assign ioff = instr_address - `MIPS_RESET_VECTOR;

  always_comb begin
    if (ioff < 32'(4 * PROG_LEN)) begin
      instr_readdata = prog[ioff[7:2]];
    end else begin
      instr_readdata = 32'h0;
    end
  end

  // data memory, 64-word window
  always_comb begin
    if (data_address[31:8] == DMEM_BASE[31:8]) begin
      data_readdata = dmem[data_address[7:2]];
    end else begin
      data_readdata = 32'h0;
    end
  end

  // refilled while reset is held
  always @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < DMEM_WORDS; k++) begin
        dmem[k] <= fill_word(DMEM_BASE + 32'(4 * k));
      end
    end else if (clk_enable && data_write && data_address[31:8] == DMEM_BASE[31:8]) begin
      dmem[data_address[7:2]] <= data_writedata;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] rand_next();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [4:0] rand_reg();
    // r20 holds the data window base and is never a destination
    return 5'(rand_next() % 32'd20);
  endfunction

  // initial memory contents depend on every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h6d2b_79f5;
  endfunction

  function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [4:0] sh,
                                        input logic [5:0] fn);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic gen_program();
    int          kind;
    int          t;
    logic        prev_branch;
    logic [31:0] r;
    logic [31:0] tgt;
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [5:0]  fn;
    logic [5:0]  op;
    // prologue sets the load/store base
    prog[0] = enc_i(6'h0F, 5'd0, 5'd20, DMEM_BASE[31:16]);
    prog[1] = enc_i(6'h0D, 5'd20, 5'd20, DMEM_BASE[15:0]);
    prev_branch = 1'b0;
    for (int i = 2; i < PROG_LEN - 2; i++) begin
      r = rand_next();
      kind = int'(r % 32'd16);
      // no branch in a delay slot, none right before the final jr
      if (kind >= 14 && (prev_branch || i > PROG_LEN - 4)) begin
        kind = 8;
      end
      rd = rand_reg();
      rs = rand_reg();
      rt = rand_reg();
      if (kind < 8) begin
        case (rand_next() % 32'd11)
          32'd0:   fn = 6'h21;
          32'd1:   fn = 6'h23;
          32'd2:   fn = 6'h24;
          32'd3:   fn = 6'h25;
          32'd4:   fn = 6'h26;
          32'd5:   fn = 6'h27;
          32'd6:   fn = 6'h2A;
          32'd7:   fn = 6'h2B;
          32'd8:   fn = 6'h00;
          32'd9:   fn = 6'h02;
          default: fn = 6'h03;
        endcase
        prog[i] = enc_r(rs, rt, rd, r[12:8], fn);
      end else if (kind < 12) begin
        op = 6'h09 + 6'(rand_next() % 32'd7);
        prog[i] = enc_i(op, (op == 6'h0F) ? 5'd0 : rs, rd, r[27:12]);
      end else if (kind == 12) begin
        prog[i] = enc_i(6'h23, 5'd20, rd, 16'(4 * (rand_next() % 32'd64)));
      end else if (kind == 13) begin
        prog[i] = enc_i(6'h2B, 5'd20, rt, 16'(4 * (rand_next() % 32'd64)));
      end else begin
        // forward target past the delay slot, at most the final jr
        t = i + 2 + int'(rand_next() % 32'(PROG_LEN - 3 - i));
        tgt = `MIPS_RESET_VECTOR + 32'(4 * t);
        if (kind == 14) begin
          prog[i] = enc_i(r[20] ? 6'h04 : 6'h05, rs, rt, 16'(t - (i + 1)));
        end else begin
          prog[i] = {r[20] ? 6'h03 : 6'h02, tgt[27:2]};
        end
      end
      prev_branch = (kind >= 14);
    end
    prog[PROG_LEN - 2] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, 6'h08);
    prog[PROG_LEN - 1] = 32'h0;
  endtask

  // ISA model with one delay slot per branch or jump
  task automatic model_run();
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] nnpc;
    logic [31:0] idx;
    logic [31:0] ins;
    logic [31:0] rs_v;
    logic [31:0] rt_v;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [31:0] res;
    logic [31:0] addr;
    logic [4:0]  dst;
    logic        wr;
    int          steps;
    for (int k = 0; k < 32; k++) begin
      ref_regs[k] = 32'h0;
    end
    for (int k = 0; k < DMEM_WORDS; k++) begin
      ref_dmem[k] = fill_word(DMEM_BASE + 32'(4 * k));
    end
    pc_trace.delete();
    st_addr.delete();
    st_data.delete();
    ld_addr.delete();
    pc = `MIPS_RESET_VECTOR;
    npc = pc + 32'd4;
    steps = 0;
    while (1) begin
      pc_trace.push_back(pc);
      if (pc == `MIPS_HALT_ADDR) begin
        break;
      end
      steps++;
      if (steps > 4 * PROG_LEN) begin
        $display("reference model never reached the halt address");
        abort_run();
      end
      idx = (pc - `MIPS_RESET_VECTOR) >> 2;
      ins = (idx < 32'(PROG_LEN)) ? prog[idx[5:0]] : 32'h0;
      rs_v = ref_regs[ins[25:21]];
      rt_v = ref_regs[ins[20:16]];
      sext = {{16{ins[15]}}, ins[15:0]};
      zext = {16'h0, ins[15:0]};
      addr = rs_v + sext;
      nnpc = npc + 32'd4;
      wr = 1'b0;
      dst = ins[20:16];
      res = 32'h0;
      case (ins[31:26])
        6'h00: begin
          wr = 1'b1;
          dst = ins[15:11];
          case (ins[5:0])
            6'h00: res = rt_v << ins[10:6];
            6'h02: res = rt_v >> ins[10:6];
            6'h03: res = $signed(rt_v) >>> ins[10:6];
            6'h21: res = rs_v + rt_v;
            6'h23: res = rs_v - rt_v;
            6'h24: res = rs_v & rt_v;
            6'h25: res = rs_v | rt_v;
            6'h26: res = rs_v ^ rt_v;
            6'h27: res = ~(rs_v | rt_v);
            6'h2A: res = {31'h0, $signed(rs_v) < $signed(rt_v)};
            6'h2B: res = {31'h0, rs_v < rt_v};
            6'h08: begin
              wr = 1'b0;
              nnpc = rs_v;
            end
            default: wr = 1'b0;
          endcase
        end
        6'h09: {wr, res} = {1'b1, rs_v + sext};
        6'h0A: {wr, res} = {1'b1, 31'h0, $signed(rs_v) < $signed(sext)};
        6'h0B: {wr, res} = {1'b1, 31'h0, rs_v < sext};
        6'h0C: {wr, res} = {1'b1, rs_v & zext};
        6'h0D: {wr, res} = {1'b1, rs_v | zext};
        6'h0E: {wr, res} = {1'b1, rs_v ^ zext};
        6'h0F: {wr, res} = {1'b1, ins[15:0], 16'h0};
        6'h23: begin
          {wr, res} = {1'b1, ref_dmem[addr[7:2]]};
          ld_addr.push_back(addr);
        end
        6'h2B: begin
          ref_dmem[addr[7:2]] = rt_v;
          st_addr.push_back(addr);
          st_data.push_back(rt_v);
        end
        6'h04: if (rs_v == rt_v) nnpc = npc + {sext[29:0], 2'b00};
        6'h05: if (rs_v != rt_v) nnpc = npc + {sext[29:0], 2'b00};
        6'h02: nnpc = {npc[31:28], ins[25:0], 2'b00};
        6'h03: begin
          nnpc = {npc[31:28], ins[25:0], 2'b00};
          wr = 1'b1;
          dst = `MIPS_REG_RA;
          res = pc + 32'd8;
        end
        default: wr = 1'b0;
      endcase
      if (wr && dst != 5'd0) begin
        ref_regs[dst] = res;
      end
      pc = npc;
      npc = nnpc;
    end
  endtask

  task automatic run_program(input logic random_en);
    int          pi;
    int          si;
    int          li;
    logic        last_en;
    logic [31:0] held_pc;
    gen_program();
    model_run();
    @(negedge clk);
    reset = 1'b1;
    clk_enable = 1'b1;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    check("active", {31'h0, active}, 32'd1);
    check("instr_address", instr_address, `MIPS_RESET_VECTOR);
    check("data_write", {31'h0, data_write}, 32'd0);
    check("data_read", {31'h0, data_read}, 32'd0);
    pi = 0;
    si = 0;
    li = 0;
    last_en = 1'b1;
    held_pc = instr_address;
    while (active === 1'b1) begin
      if (!last_en) begin
        check("instr_address", instr_address, held_pc);
      end
      clk_enable = random_en ? (rand_next() % 32'd10 < 32'd8) : 1'b1;
      // values seen now are taken at the coming rising edge
      if (clk_enable) begin
        if (pi >= pc_trace.size()) begin
          $display("core fetched past the end of the reference pc trace");
          abort_run();
        end
        check("instr_address", instr_address, pc_trace[pi]);
        pi++;
        if (data_write) begin
          if (si >= st_addr.size()) begin
            $display("core stored more words than the reference model");
            abort_run();
          end
          check("data_address", data_address, st_addr[si]);
          check("data_writedata", data_writedata, st_data[si]);
          si++;
        end
        if (data_read) begin
          if (li >= ld_addr.size()) begin
            $display("core loaded more words than the reference model");
            abort_run();
          end
          check("data_address", data_address, ld_addr[li]);
          li++;
        end
      end
      last_en = clk_enable;
      held_pc = instr_address;
      @(negedge clk);
    end
    check("fetch count", 32'(pi), 32'(pc_trace.size()));
    check("store count", 32'(si), 32'(st_addr.size()));
    check("load count", 32'(li), 32'(ld_addr.size()));
    // halted state must hold
    repeat (4) begin
      clk_enable = rand_next() % 32'd2 == 32'd0;
      @(negedge clk);
      check("active", {31'h0, active}, 32'd0);
      check("data_write", {31'h0, data_write}, 32'd0);
      check("data_read", {31'h0, data_read}, 32'd0);
      check("instr_address", instr_address, `MIPS_HALT_ADDR);
    end
    check("register_v0", register_v0, ref_regs[`MIPS_REG_V0]);
    for (int k = 0; k < DMEM_WORDS; k++) begin
      check($sformatf("dmem[%0d]", k), dmem[k], ref_dmem[k]);
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the programs did not finish within %0d ns", TIMEOUT_NS);
    abort_run();
  end

  initial begin
    reset = 1'b1;
    clk_enable = 1'b0;
    rng_state = 32'h203e_3c81;
    for (int k = 0; k < 64; k++) begin
      prog[k] = 32'h0;
    end
    // first half at full speed, second half with clk_enable gaps
    for (int p = 0; p < NUM_PROGS; p++) begin
      run_program(p >= NUM_PROGS / 2);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mips_cpu -f verilog.f -o sim_mips

# the simulator exits nonzero on failure, the log decides
./obj_dir/sim_mips > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
  exit 1
fi
exit 0

//--- verilog.f
+incdir+verilog
verilog/mips_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/fetch_unit.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mips_cpu_harvard.sv
bench/tb_clock_gen.sv
bench/tb_mips_cpu.sv

//--- verilog/alu.sv
module alu (
  input  mips_pkg::alu_op_t op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  input  logic [4:0]        shamt,
  output logic [31:0]       result
);
  import mips_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_NOR:  result = ~(a | b);
      ALU_SLT:  result = {31'h0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'h0, a < b};
      // shifts act on the rt operand
      ALU_SLL:  result = b << shamt;
      ALU_SRL:  result = b >> shamt;
      ALU_SRA:  result = $signed(b) >>> shamt;
      ALU_LUI:  result = {b[15:0], 16'h0000};
      default:  result = 32'h0;
    endcase
  end

endmodule

//--- verilog/decode_stage.sv
`include "mips_params.svh"

module decode_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 clk_enable,
  input  mips_pkg::cpu_state_t state,
  input  logic [31:0]          instr,
  input  logic [31:0]          pc_plus4,
  input  logic [31:0]          rdata_a,
  input  logic [31:0]          rdata_b,
  input  mips_pkg::wb_t        wb,
  output logic [4:0]           raddr_a,
  output logic [4:0]           raddr_b,
  output logic                 redirect,
  output logic [31:0]          target,
  output mips_pkg::ex_op_t     ex_op
);
  import mips_pkg::*;

  opcode_t     opcode;
  funct_t      funct;
  logic        issue;
  logic [31:0] rs_val;
  logic [31:0] rt_val;
  logic [31:0] imm_ext;
  logic        use_imm, zero_ext;
  logic        reg_write, mem_read, mem_write, link;
  logic        is_beq, is_bne, is_jump, is_jr;
  alu_op_t     alu_op;
  logic [4:0]  dest;
  ex_op_t      ex_next;

  assign opcode  = opcode_t'(instr[31:26]);
  assign funct   = funct_t'(instr[5:0]);
  assign raddr_a = instr[25:21];
  assign raddr_b = instr[20:16];

  // nothing issues while halted or at the halt address
  assign issue = (state == CPU_RUN) && ((pc_plus4 - 32'd4) != `MIPS_HALT_ADDR);

  // forward the result of the instruction in execute
  assign rs_val = (wb.reg_write && wb.dest == raddr_a && raddr_a != 5'd0) ? wb.data : rdata_a;
  assign rt_val = (wb.reg_write && wb.dest == raddr_b && raddr_b != 5'd0) ? wb.data : rdata_b;

  assign imm_ext = zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

  always_comb begin
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    zero_ext  = 1'b0;
    dest      = instr[15:11];
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    link      = 1'b0;
    is_beq    = 1'b0;
    is_bne    = 1'b0;
    is_jump   = 1'b0;
    is_jr     = 1'b0;
    case (opcode)
      OP_SPECIAL: begin
        reg_write = 1'b1;
        case (funct)
          FN_SLL:  alu_op = ALU_SLL;
          FN_SRL:  alu_op = ALU_SRL;
          FN_SRA:  alu_op = ALU_SRA;
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_NOR:  alu_op = ALU_NOR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLTU: alu_op = ALU_SLTU;
          FN_JR: begin
            reg_write = 1'b0;
            is_jr     = 1'b1;
          end
          default: reg_write = 1'b0;
        endcase
      end
      OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        use_imm   = 1'b1;
        dest      = instr[20:16];
        reg_write = 1'b1;
        zero_ext  = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
        case (opcode)
          OP_SLTI:  alu_op = ALU_SLT;
          OP_SLTIU: alu_op = ALU_SLTU;
          OP_ANDI:  alu_op = ALU_AND;
          OP_ORI:   alu_op = ALU_OR;
          OP_XORI:  alu_op = ALU_XOR;
          OP_LUI:   alu_op = ALU_LUI;
          default:  alu_op = ALU_ADD;
        endcase
      end
      OP_LW: begin
        use_imm   = 1'b1;
        dest      = instr[20:16];
        reg_write = 1'b1;
        mem_read  = 1'b1;
      end
      OP_SW: begin
        use_imm   = 1'b1;
        mem_write = 1'b1;
      end
      OP_BEQ: is_beq = 1'b1;
      OP_BNE: is_bne = 1'b1;
      OP_J:   is_jump = 1'b1;
      OP_JAL: begin
        is_jump   = 1'b1;
        link      = 1'b1;
        dest      = `MIPS_REG_RA;
        reg_write = 1'b1;
      end
      default: reg_write = 1'b0;
    endcase
  end

  // branch and jump resolution
  always_comb begin
    if (is_jr) begin
      target = rs_val;
    end else if (is_jump) begin
      target = {pc_plus4[31:28], instr[25:0], 2'b00};
    end else begin
      target = pc_plus4 + {imm_ext[29:0], 2'b00};
    end
  end

  assign redirect = issue && (is_jump || is_jr || (is_beq && rs_val == rt_val) ||
                              (is_bne && rs_val != rt_val));

  always_comb begin
    ex_next.valid      = issue;
    ex_next.alu_op     = alu_op;
    ex_next.operand_a  = rs_val;
    ex_next.operand_b  = use_imm ? imm_ext : rt_val;
    ex_next.shamt      = instr[10:6];
    ex_next.store_data = rt_val;
    ex_next.mem_read   = mem_read;
    ex_next.mem_write  = mem_write;
    ex_next.link       = link;
    // return address skips the delay slot
    ex_next.link_addr  = pc_plus4 + 32'd4;
    ex_next.dest       = dest;
    ex_next.reg_write  = reg_write;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_op.valid <= 1'b0;
    end else if (clk_enable) begin
      ex_op <= ex_next;
    end
  end

endmodule

//--- verilog/execute_stage.sv
module execute_stage (
  input  mips_pkg::ex_op_t ex_op,
  input  logic [31:0]      data_readdata,
  output logic [31:0]      data_address,
  output logic             data_read,
  output logic             data_write,
  output logic [31:0]      data_writedata,
  output mips_pkg::wb_t    wb
);

  logic [31:0] alu_result;

  alu u_alu (
    .op     (ex_op.alu_op),
    .a      (ex_op.operand_a),
    .b      (ex_op.operand_b),
    .shamt  (ex_op.shamt),
    .result (alu_result)
  );

  // effective address comes straight from the adder
  assign data_address   = alu_result;
  assign data_read      = ex_op.valid && ex_op.mem_read;
  assign data_write     = ex_op.valid && ex_op.mem_write;
  assign data_writedata = ex_op.store_data;

  always_comb begin
    wb.reg_write = ex_op.valid && ex_op.reg_write;
    wb.dest      = ex_op.dest;
    if (ex_op.mem_read) begin
      wb.data = data_readdata;
    end else if (ex_op.link) begin
      wb.data = ex_op.link_addr;
    end else begin
      wb.data = alu_result;
    end
  end

endmodule

//--- verilog/fetch_unit.sv
`include "mips_params.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 clk_enable,
  input  logic                 redirect,
  input  logic [31:0]          target,
  output logic [31:0]          pc,
  output logic [31:0]          pc_plus4,
  output mips_pkg::cpu_state_t state
);
  import mips_pkg::*;

  // target waiting for the delay slot to be fetched
  logic        pend_valid;
  logic [31:0] pend_target;

  assign pc_plus4 = pc + 32'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= `MIPS_RESET_VECTOR;
      state      <= CPU_RUN;
      pend_valid <= 1'b0;
    end else if (clk_enable && state == CPU_RUN) begin
      if (pc == `MIPS_HALT_ADDR) begin
        // pc stays put from here on
        state      <= CPU_HALTED;
        pend_valid <= 1'b0;
      end else begin
        pc         <= pend_valid ? pend_target : pc_plus4;
        pend_valid <= redirect;
      end
    end
  end

  // holder payload, qualified by pend_valid
  always_ff @(posedge clk) begin
    if (clk_enable && redirect) begin
      pend_target <= target;
    end
  end

endmodule

//--- verilog/mips_cpu_harvard.sv
module mips_cpu_harvard (
  input  logic        clk,
  input  logic        reset,
  output logic        active,
  output logic [31:0] register_v0,

  input  logic        clk_enable,

  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,

  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);
  import mips_pkg::*;

  logic [31:0] pc_plus4;
  logic        redirect;
  logic [31:0] target;
  cpu_state_t  state;
  logic [4:0]  raddr_a;
  logic [4:0]  raddr_b;
  logic [31:0] rdata_a;
  logic [31:0] rdata_b;
  ex_op_t      ex_op;
  wb_t         wb;

  assign active = (state == CPU_RUN);

  fetch_unit u_fetch (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .redirect   (redirect),
    .target     (target),
    .pc         (instr_address),
    .pc_plus4   (pc_plus4),
    .state      (state)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .state      (state),
    .instr      (instr_readdata),
    .pc_plus4   (pc_plus4),
    .rdata_a    (rdata_a),
    .rdata_b    (rdata_b),
    .wb         (wb),
    .raddr_a    (raddr_a),
    .raddr_b    (raddr_b),
    .redirect   (redirect),
    .target     (target),
    .ex_op      (ex_op)
  );

  register_file u_regs (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .raddr_a     (raddr_a),
    .raddr_b     (raddr_b),
    .wb          (wb),
    .rdata_a     (rdata_a),
    .rdata_b     (rdata_b),
    .register_v0 (register_v0)
  );

  execute_stage u_execute (
    .ex_op          (ex_op),
    .data_readdata  (data_readdata),
    .data_address   (data_address),
    .data_read      (data_read),
    .data_write     (data_write),
    .data_writedata (data_writedata),
    .wb             (wb)
  );

endmodule

//--- verilog/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// first fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// fetching from this address stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

// result register, exported on register_v0
`define MIPS_REG_V0 5'd2

// link register written by jal
`define MIPS_REG_RA 5'd31

`endif

//--- verilog/mips_pkg.sv
package mips_pkg;

  // primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0A,
    OP_SLTIU   = 6'h0B,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_XORI    = 6'h0E,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  // function codes under SPECIAL, instr[5:0]
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_SRA  = 6'h03,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2A,
    FN_SLTU = 6'h2B
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
  } alu_op_t;

  typedef enum logic {
    CPU_RUN    = 1'b0,
    CPU_HALTED = 1'b1
  } cpu_state_t;

  // decode -> execute pipeline register
  typedef struct packed {
    logic        valid;
    alu_op_t     alu_op;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [4:0]  shamt;
    logic [31:0] store_data;
    logic        mem_read;
    logic        mem_write;
    logic        link;
    logic [31:0] link_addr;
    logic [4:0]  dest;
    logic        reg_write;
  } ex_op_t;

  // execute -> register file and bypass
  typedef struct packed {
    logic        reg_write;
    logic [4:0]  dest;
    logic [31:0] data;
  } wb_t;

endpackage

//--- verilog/register_file.sv
`include "mips_params.svh"

module register_file (
  input  logic          clk,
  input  logic          reset,
  input  logic          clk_enable,
  input  logic [4:0]    raddr_a,
  input  logic [4:0]    raddr_b,
  input  mips_pkg::wb_t wb,
  output logic [31:0]   rdata_a,
  output logic [31:0]   rdata_b,
  output logic [31:0]   register_v0
);

  logic [31:0] regs [32];

  // r0 always reads as zero
  assign rdata_a     = (raddr_a == 5'd0) ? 32'h0 : regs[raddr_a];
  assign rdata_b     = (raddr_b == 5'd0) ? 32'h0 : regs[raddr_b];
  assign register_v0 = regs[`MIPS_REG_V0];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'h0;
      end
    end else if (clk_enable && wb.reg_write && wb.dest != 5'd0) begin
      regs[wb.dest] <= wb.data;
    end
  end

endmodule
